//--- rvv_pkg.sv
// vector decode package
package rvv_pkg;

  // instruction slots seen by the decoder per cycle
  localparam int num_de_inst = 2;

  // micro-op push lanes per cycle
  localparam int num_de_uop = 4;

  // slot-0 micro-op count, 0 to 4
  localparam int num_de_uop_width = 3;

  // micro-op index, 0 to 7
  localparam int uop_index_width = 3;

  // lmul code 0..3 gives 1, 2, 4 or 8 micro-ops
  localparam int lmul_width = 2;

  // instruction tag and vector register number
  localparam int tag_width  = 8;
  localparam int vreg_width = 5;

  // command queue sizing
  localparam int cq_depth     = 4;
  localparam int cq_ptr_width = $clog2(cq_depth);
  localparam int cq_cnt_width = $clog2(cq_depth + 1);

  // micro-op queue sizing
  localparam int uq_depth     = 8;
  localparam int uq_ptr_width = $clog2(uq_depth);
  localparam int uq_cnt_width = $clog2(uq_depth + 1);

endpackage

//--- rvv_cmd_queue.sv
// vector command queue
`timescale 1ns/10ps

module rvv_cmd_queue (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  logic                                                      in_req,
  input  logic [rvv_pkg::tag_width-1:0]                             in_tag,
  input  logic [rvv_pkg::lmul_width-1:0]                            in_lmul,
  input  logic [rvv_pkg::vreg_width-1:0]                            in_vd,
  output logic                                                      in_ack,
  input  logic [rvv_pkg::num_de_inst-1:0]                           pop,
  output logic [rvv_pkg::num_de_inst-1:0]                           cq_valid,
  output logic [rvv_pkg::num_de_inst-1:0][rvv_pkg::tag_width-1:0]   cq_tag,
  output logic [rvv_pkg::num_de_inst-1:0][rvv_pkg::lmul_width-1:0]  cq_lmul,
  output logic [rvv_pkg::num_de_inst-1:0][rvv_pkg::vreg_width-1:0]  cq_vd
);
  import rvv_pkg::*;

  logic [tag_width-1:0]    tag_mem  [cq_depth];
  logic [lmul_width-1:0]   lmul_mem [cq_depth];
  logic [vreg_width-1:0]   vd_mem   [cq_depth];
  logic [cq_ptr_width-1:0] rd_ptr;
  logic [cq_ptr_width-1:0] wr_ptr;
  logic [cq_cnt_width-1:0] count;
  logic [1:0]              pop_cnt;
  logic                    wr_en;

  // one write per req phase, only with space free
  assign wr_en   = in_req && !in_ack && (count < cq_cnt_width'(cq_depth));
  assign pop_cnt = {1'b0, pop[0]} + {1'b0, pop[1]};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_ack <= 1'b0;
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      // ack holds the write until req falls
      if (wr_en) begin
        in_ack <= 1'b1;
      end else if (!in_req) begin
        in_ack <= 1'b0;
      end
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      rd_ptr <= rd_ptr + cq_ptr_width'(pop_cnt);
      count  <= count + cq_cnt_width'(wr_en) - cq_cnt_width'(pop_cnt);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_ptr]  <= in_tag;
      lmul_mem[wr_ptr] <= in_lmul;
      vd_mem[wr_ptr]   <= in_vd;
    end
  end

  // two oldest entries, slot 1 only behind slot 0
  always_comb begin
    for (int s = 0; s < num_de_inst; s++) begin
      cq_valid[s] = count > cq_cnt_width'(s);
      cq_tag[s]   = tag_mem[cq_ptr_width'(rd_ptr + s)];
      cq_lmul[s]  = lmul_mem[cq_ptr_width'(rd_ptr + s)];
      cq_vd[s]    = vd_mem[cq_ptr_width'(rd_ptr + s)];
    end
  end

  // controller never pops past what is stored
  assert property (@(posedge clk) disable iff (!rst_n)
    cq_cnt_width'(pop_cnt) <= count);

endmodule

//--- rvv_decode_unit.sv
// vector micro-op expansion
`timescale 1ns/10ps

module rvv_decode_unit (
  input  logic [rvv_pkg::num_de_inst-1:0]                           cq_valid,
  input  logic [rvv_pkg::num_de_inst-1:0][rvv_pkg::tag_width-1:0]   cq_tag,
  input  logic [rvv_pkg::num_de_inst-1:0][rvv_pkg::lmul_width-1:0]  cq_lmul,
  input  logic [rvv_pkg::num_de_inst-1:0][rvv_pkg::vreg_width-1:0]  cq_vd,
  input  logic [rvv_pkg::uop_index_width-1:0]                       uop_index_remain,
  output logic [rvv_pkg::num_de_inst-1:0]                           pkg_valid,
  output logic [rvv_pkg::num_de_inst-1:0][rvv_pkg::num_de_uop-1:0]  uop_valid,
  output logic [rvv_pkg::num_de_inst-1:0][rvv_pkg::num_de_uop-1:0]
               [rvv_pkg::tag_width-1:0]                             uop_tag,
  output logic [rvv_pkg::num_de_inst-1:0][rvv_pkg::num_de_uop-1:0]
               [rvv_pkg::uop_index_width-1:0]                       uop_index,
  output logic [rvv_pkg::num_de_inst-1:0][rvv_pkg::num_de_uop-1:0]
               [rvv_pkg::vreg_width-1:0]                            uop_vd,
  output logic [rvv_pkg::num_de_inst-1:0][rvv_pkg::num_de_uop-1:0]  uop_last
);
  import rvv_pkg::*;

  assign pkg_valid = cq_valid;

  for (genvar s = 0; s < num_de_inst; s++) begin : g_slot
    // one extra bit so count 8 and index overrun fit
    logic [uop_index_width:0] uop_cnt;
    logic [uop_index_width:0] base;

    assign uop_cnt = (uop_index_width + 1)'(1) << cq_lmul[s];

    // only the oldest slot can be partly sent
    if (s == 0) begin : g_head
      assign base = {1'b0, uop_index_remain};
    end else begin : g_next
      assign base = '0;
    end

    for (genvar k = 0; k < num_de_uop; k++) begin : g_lane
      logic [uop_index_width:0] idx;

      assign idx = base + (uop_index_width + 1)'(k);

      assign uop_valid[s][k] = cq_valid[s] && (idx < uop_cnt);
      assign uop_last[s][k]  = cq_valid[s] && (idx == uop_cnt - 1'b1);
      assign uop_tag[s][k]   = cq_tag[s];
      assign uop_index[s][k] = idx[uop_index_width-1:0];
      // destination steps through the register group
      assign uop_vd[s][k]    = cq_vd[s] + vreg_width'(idx[uop_index_width-1:0]);
    end
  end

endmodule

//--- rvv_decode_ctrl.sv
// vector decode controller
`timescale 1ns/10ps

module rvv_decode_ctrl (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  logic [rvv_pkg::num_de_inst-1:0]                           pkg_valid,
  input  logic [rvv_pkg::num_de_inst-1:0][rvv_pkg::num_de_uop-1:0]  uop_valid,
  input  logic [rvv_pkg::num_de_inst-1:0][rvv_pkg::num_de_uop-1:0]
               [rvv_pkg::tag_width-1:0]                             uop_tag,
  input  logic [rvv_pkg::num_de_inst-1:0][rvv_pkg::num_de_uop-1:0]
               [rvv_pkg::uop_index_width-1:0]                       uop_index,
  input  logic [rvv_pkg::num_de_inst-1:0][rvv_pkg::num_de_uop-1:0]
               [rvv_pkg::vreg_width-1:0]                            uop_vd,
  input  logic [rvv_pkg::num_de_inst-1:0][rvv_pkg::num_de_uop-1:0]  uop_last,
  input  logic                                                      uq_full,
  input  logic [rvv_pkg::num_de_uop-1:1]                            uq_almost_full,
  output logic [rvv_pkg::uop_index_width-1:0]                       uop_index_remain,
  output logic [rvv_pkg::num_de_inst-1:0]                           pop,
  output logic [rvv_pkg::num_de_uop-1:0]                            push,
  output logic [rvv_pkg::num_de_uop-1:0][rvv_pkg::tag_width-1:0]    push_tag,
  output logic [rvv_pkg::num_de_uop-1:0][rvv_pkg::uop_index_width-1:0] push_index,
  output logic [rvv_pkg::num_de_uop-1:0][rvv_pkg::vreg_width-1:0]   push_vd,
  output logic [rvv_pkg::num_de_uop-1:0]                            push_last
);
  import rvv_pkg::*;

  logic [num_de_uop_width-1:0] quantity;
  logic [num_de_uop-1:0]       push_valid;
  logic [num_de_inst-1:0]      last_uop_unit;
  logic                        fifo_ready;
  logic                        index_clear;
  logic                        index_en_unit0;
  logic                        index_en_unit1;
  logic [uop_index_width-1:0]  index_din;

  // valids are contiguous from lane 0
  always_comb begin
    quantity = '0;
    for (int k = 0; k < num_de_uop; k++) begin
      if (uop_valid[0][k]) begin
        quantity = num_de_uop_width'(k + 1);
      end
    end
  end

  assign fifo_ready = !(uq_full || (|uq_almost_full));

  // lanes below quantity take slot 0, the rest take slot 1 shifted down
  always_comb begin
    last_uop_unit[0] = |(uop_valid[0] & uop_last[0]);
    last_uop_unit[1] = 1'b0;
    for (int j = 0; j < num_de_uop; j++) begin
      if (j < quantity) begin
        push_valid[j] = uop_valid[0][j];
        push_tag[j]   = uop_tag[0][j];
        push_index[j] = uop_index[0][j];
        push_vd[j]    = uop_vd[0][j];
        push_last[j]  = uop_last[0][j];
      end else begin
        push_valid[j] = uop_valid[1][j - quantity];
        push_tag[j]   = uop_tag[1][j - quantity];
        push_index[j] = uop_index[1][j - quantity];
        push_vd[j]    = uop_vd[1][j - quantity];
        push_last[j]  = uop_last[1][j - quantity];
        last_uop_unit[1] = last_uop_unit[1] | (push_valid[j] & push_last[j]);
      end
    end
  end

  assign push = push_valid & {num_de_uop{fifo_ready}};

  // a slot pops once its last micro-op goes out
  assign pop[0] = pkg_valid[0] &&
                  ((last_uop_unit[0] && fifo_ready) || (uop_valid[0] == '0));
  assign pop[1] = pop[0] && pkg_valid[1] &&
                  ((last_uop_unit[1] && fifo_ready) || (uop_valid[1] == '0));

  assign index_clear    = (pop[0] && !pkg_valid[1]) || pop[1];
  assign index_en_unit0 = pkg_valid[0] && (uop_valid[0] != '0) &&
                          !last_uop_unit[0] && fifo_ready;
  assign index_en_unit1 = pkg_valid[1] && (uop_valid[1] != '0) &&
                          !last_uop_unit[1] && fifo_ready && pop[0];

  always_comb begin
    index_din = uop_index_remain;
    if (index_en_unit0) begin
      index_din = uop_index_remain + uop_index_width'(num_de_uop);
    end else if (index_en_unit1) begin
      // slot 1 started behind slot 0 and moves up next cycle
      index_din = uop_index_width'(num_de_uop) - uop_index_width'(quantity);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      uop_index_remain <= '0;
    end else if (index_clear) begin
      uop_index_remain <= '0;
    end else if (index_en_unit0 || index_en_unit1) begin
      uop_index_remain <= index_din;
    end
  end

  // remaining index stays inside the slot-0 group
  assert property (@(posedge clk) disable iff (!rst_n) pkg_valid[0] |-> uop_valid[0][0]);

  // pushes stay packed from lane 0 upward
  assert property (@(posedge clk) disable iff (!rst_n)
    (push & (push + 1'b1)) == '0);

endmodule

//--- rvv_uop_queue.sv
// vector micro-op queue
`timescale 1ns/10ps

module rvv_uop_queue (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  logic [rvv_pkg::num_de_uop-1:0]                            push,
  input  logic [rvv_pkg::num_de_uop-1:0][rvv_pkg::tag_width-1:0]    push_tag,
  input  logic [rvv_pkg::num_de_uop-1:0][rvv_pkg::uop_index_width-1:0] push_index,
  input  logic [rvv_pkg::num_de_uop-1:0][rvv_pkg::vreg_width-1:0]   push_vd,
  input  logic [rvv_pkg::num_de_uop-1:0]                            push_last,
  output logic                                                      uq_full,
  output logic [rvv_pkg::num_de_uop-1:1]                            uq_almost_full,
  input  logic                                                      out_ack,
  output logic                                                      out_req,
  output logic [rvv_pkg::tag_width-1:0]                             out_tag,
  output logic [rvv_pkg::uop_index_width-1:0]                       out_index,
  output logic [rvv_pkg::vreg_width-1:0]                            out_vd,
  output logic                                                      out_last
);
  import rvv_pkg::*;

  logic [tag_width-1:0]       tag_mem   [uq_depth];
  logic [uop_index_width-1:0] index_mem [uq_depth];
  logic [vreg_width-1:0]      vd_mem    [uq_depth];
  logic                       last_mem  [uq_depth];
  logic [uq_ptr_width-1:0]    wr_addr   [num_de_uop];
  logic [uq_ptr_width-1:0]    rd_ptr;
  logic [uq_ptr_width-1:0]    wr_ptr;
  logic [uq_cnt_width-1:0]    count;
  logic [uq_cnt_width-1:0]    push_cnt;
  logic                       head_pop;

  always_comb begin
    push_cnt = '0;
    for (int j = 0; j < num_de_uop; j++) begin
      wr_addr[j] = wr_ptr + uq_ptr_width'(j);
      push_cnt   = push_cnt + uq_cnt_width'(push[j]);
    end
  end

  assign head_pop = out_req && out_ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_req <= 1'b0;
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      count   <= '0;
    end else begin
      // raise again only after the sink has dropped ack
      if (head_pop) begin
        out_req <= 1'b0;
      end else if (!out_req && !out_ack && (count != '0)) begin
        out_req <= 1'b1;
      end
      if (head_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      wr_ptr <= wr_ptr + uq_ptr_width'(push_cnt);
      count  <= count + push_cnt - uq_cnt_width'(head_pop);
    end
  end

  // lanes arrive packed, so lane j lands j past the write pointer
  always_ff @(posedge clk) begin
    for (int j = 0; j < num_de_uop; j++) begin
      if (push[j]) begin
        tag_mem[wr_addr[j]]   <= push_tag[j];
        index_mem[wr_addr[j]] <= push_index[j];
        vd_mem[wr_addr[j]]    <= push_vd[j];
        last_mem[wr_addr[j]]  <= push_last[j];
      end
    end
  end

  assign out_tag   = tag_mem[rd_ptr];
  assign out_index = index_mem[rd_ptr];
  assign out_vd    = vd_mem[rd_ptr];
  assign out_last  = last_mem[rd_ptr];

  assign uq_full = count == uq_cnt_width'(uq_depth);
  for (genvar j = 1; j < num_de_uop; j++) begin : g_almost
    assign uq_almost_full[j] = (uq_cnt_width'(uq_depth) - count) == uq_cnt_width'(j);
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    push_cnt <= uq_cnt_width'(uq_depth) - count);

endmodule

//--- rvv_decode_top.sv
// vector decode stage top
`timescale 1ns/10ps

module rvv_decode_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  in_req,
  input  logic [rvv_pkg::tag_width-1:0]         in_tag,
  input  logic [rvv_pkg::lmul_width-1:0]        in_lmul,
  input  logic [rvv_pkg::vreg_width-1:0]        in_vd,
  output logic                                  in_ack,
  output logic                                  out_req,
  output logic [rvv_pkg::tag_width-1:0]         out_tag,
  output logic [rvv_pkg::uop_index_width-1:0]   out_index,
  output logic [rvv_pkg::vreg_width-1:0]        out_vd,
  output logic                                  out_last,
  input  logic                                  out_ack
);
  import rvv_pkg::*;

  logic [num_de_inst-1:0]                                  cq_valid;
  logic [num_de_inst-1:0][tag_width-1:0]                   cq_tag;
  logic [num_de_inst-1:0][lmul_width-1:0]                  cq_lmul;
  logic [num_de_inst-1:0][vreg_width-1:0]                  cq_vd;
  logic [num_de_inst-1:0]                                  pop;
  logic [num_de_inst-1:0]                                  pkg_valid;
  logic [num_de_inst-1:0][num_de_uop-1:0]                  uop_valid;
  logic [num_de_inst-1:0][num_de_uop-1:0][tag_width-1:0]   uop_tag;
  logic [num_de_inst-1:0][num_de_uop-1:0][uop_index_width-1:0] uop_index;
  logic [num_de_inst-1:0][num_de_uop-1:0][vreg_width-1:0]  uop_vd;
  logic [num_de_inst-1:0][num_de_uop-1:0]                  uop_last;
  logic [uop_index_width-1:0]                              uop_index_remain;
  logic [num_de_uop-1:0]                                   push;
  logic [num_de_uop-1:0][tag_width-1:0]                    push_tag;
  logic [num_de_uop-1:0][uop_index_width-1:0]              push_index;
  logic [num_de_uop-1:0][vreg_width-1:0]                   push_vd;
  logic [num_de_uop-1:0]                                   push_last;
  logic                                                    uq_full;
  logic [num_de_uop-1:1]                                   uq_almost_full;

  rvv_cmd_queue cmd_queue_i (
    .clk, .rst_n, .in_req, .in_tag, .in_lmul, .in_vd, .in_ack,
    .pop, .cq_valid, .cq_tag, .cq_lmul, .cq_vd
  );

  rvv_decode_unit decode_unit_i (
    .cq_valid, .cq_tag, .cq_lmul, .cq_vd, .uop_index_remain,
    .pkg_valid, .uop_valid, .uop_tag, .uop_index, .uop_vd, .uop_last
  );

  rvv_decode_ctrl decode_ctrl_i (
    .clk, .rst_n, .pkg_valid, .uop_valid, .uop_tag, .uop_index, .uop_vd, .uop_last,
    .uq_full, .uq_almost_full, .uop_index_remain, .pop,
    .push, .push_tag, .push_index, .push_vd, .push_last
  );

  rvv_uop_queue uop_queue_i (
    .clk, .rst_n, .push, .push_tag, .push_index, .push_vd, .push_last,
    .uq_full, .uq_almost_full,
    .out_ack, .out_req, .out_tag, .out_index, .out_vd, .out_last
  );

endmodule

//--- rvv_decode_tb.sv
// vector decode stage testbench
`timescale 1ns/10ps

module rvv_decode_tb;
  import rvv_pkg::*;

  localparam int clk_period = 100;
  localparam int wait_limit = 500;
  localparam int bp_cmds    = 12;

  typedef struct packed {
    logic [tag_width-1:0]       tag;
    logic [uop_index_width-1:0] index;
    logic [vreg_width-1:0]      vd;
    logic                       last;
  } uop_t;

  logic                       clk;
  logic                       rst_n;
  logic                       in_req;
  logic [tag_width-1:0]       in_tag;
  logic [lmul_width-1:0]      in_lmul;
  logic [vreg_width-1:0]      in_vd;
  logic                       in_ack;
  logic                       out_req;
  logic [tag_width-1:0]       out_tag;
  logic [uop_index_width-1:0] out_index;
  logic [vreg_width-1:0]      out_vd;
  logic                       out_last;
  logic                       out_ack;

  // micro-ops still expected at the output, oldest first
  uop_t exp_q[$];

  rvv_decode_top dut_i (
    .clk, .rst_n, .in_req, .in_tag, .in_lmul, .in_vd, .in_ack,
    .out_req, .out_tag, .out_index, .out_vd, .out_last, .out_ack
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s expected %0h actual %0h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped after a timeout");
  endtask

  // reference expansion: count from lmul, vd steps with the index
  function automatic void expand_cmd(input logic [tag_width-1:0] tag,
                                     input logic [lmul_width-1:0] lmul,
                                     input logic [vreg_width-1:0] vd);
    int   n;
    uop_t u;
    n = 1 << lmul;
    for (int i = 0; i < n; i++) begin
      u.tag   = tag;
      u.index = uop_index_width'(i);
      u.vd    = vd + vreg_width'(i);
      u.last  = (i == n - 1);
      exp_q.push_back(u);
    end
  endfunction

  task automatic send_cmd(input logic [tag_width-1:0] tag,
                          input logic [lmul_width-1:0] lmul,
                          input logic [vreg_width-1:0] vd);
    int cycles;
    @(posedge clk);
    in_req  <= 1'b1;
    in_tag  <= tag;
    in_lmul <= lmul;
    in_vd   <= vd;
    cycles = 0;
    @(posedge clk);
    while (!in_ack) begin
      cycles++;
      if (cycles > wait_limit) stop_on_timeout("in_ack to rise");
      @(posedge clk);
    end
    // ack means the command was written
    expand_cmd(tag, lmul, vd);
    in_req <= 1'b0;
    cycles = 0;
    @(posedge clk);
    while (in_ack) begin
      cycles++;
      if (cycles > wait_limit) stop_on_timeout("in_ack to fall");
      @(posedge clk);
    end
  endtask

  task automatic recv_uop(input string name, input int delay);
    uop_t        exp_uop;
    logic [31:0] held;
    int          cycles;
    cycles = 0;
    @(posedge clk);
    while (!out_req) begin
      cycles++;
      if (cycles > wait_limit) stop_on_timeout("out_req to rise");
      @(posedge clk);
    end
    if (exp_q.size() == 0) begin
      $display("a micro-op came out with no command left to expand");
      $display("TEST FAILED");
      $fatal(1, "unexpected micro-op in %s", name);
    end
    exp_uop = exp_q.pop_front();
    check({name, " tag"}, exp_uop.tag, out_tag);
    check({name, " index"}, exp_uop.index, out_index);
    check({name, " vd"}, exp_uop.vd, out_vd);
    check({name, " last"}, exp_uop.last, out_last);
    held = {out_tag, out_index, out_vd, out_last};
    // fields must hold while the sink is slow
    for (int d = 0; d < delay; d++) begin
      @(posedge clk);
      check({name, " req held"}, 1, out_req);
      check({name, " fields held"}, held, {out_tag, out_index, out_vd, out_last});
    end
    out_ack <= 1'b1;
    cycles = 0;
    @(posedge clk);
    while (out_req) begin
      cycles++;
      if (cycles > wait_limit) stop_on_timeout("out_req to fall");
      @(posedge clk);
    end
    out_ack <= 1'b0;
  endtask

  task automatic drain_uops(input string name, input int n, input int max_delay);
    for (int i = 0; i < n; i++) begin
      recv_uop(name, $urandom_range(max_delay, 0));
    end
    check({name, " leftover"}, 0, exp_q.size());
    // no extra micro-op may follow
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      check({name, " no extra uop"}, 0, out_req);
    end
  endtask

  task automatic test_reset_idle();
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      check("reset in_ack", 0, in_ack);
      check("reset out_req", 0, out_req);
    end
  endtask

  task automatic test_single_uop();
    send_cmd(8'h11, 2'd0, 5'd3);
    drain_uops("single", 1, 0);
  endtask

  task automatic test_group_of_eight();
    send_cmd(8'h22, 2'd3, 5'd8);
    drain_uops("group8", 8, 0);
  endtask

  task automatic test_back_to_back();
    // a full group ahead fills the micro-op queue so slot 1 gets split
    send_cmd(8'h30, 2'd3, 5'd16);
    send_cmd(8'h31, 2'd1, 5'd2);
    send_cmd(8'h32, 2'd2, 5'd12);
    send_cmd(8'h33, 2'd0, 5'd20);
    send_cmd(8'h34, 2'd1, 5'd24);
    drain_uops("b2b", 17, 2);
  endtask

  task automatic test_back_pressure();
    logic [lmul_width-1:0] lmul_arr [bp_cmds];
    logic [vreg_width-1:0] vd_arr   [bp_cmds];
    int                    total;
    total = 0;
    for (int i = 0; i < bp_cmds; i++) begin
      lmul_arr[i] = lmul_width'($urandom_range(3, 0));
      vd_arr[i]   = vreg_width'($urandom_range(31, 0));
      total       = total + (1 << lmul_arr[i]);
    end
    fork
      begin
        for (int i = 0; i < bp_cmds; i++) begin
          send_cmd(tag_width'(8'h40 + i), lmul_arr[i], vd_arr[i]);
        end
      end
      begin
        // sink idle long enough for both queues to fill
        repeat (80) @(posedge clk);
        check("bp stalled", 1, in_req && !in_ack);
        drain_uops("bp", total, 3);
      end
    join
  endtask

  initial begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    in_req  = 1'b0;
    in_tag  = '0;
    in_lmul = '0;
    in_vd   = '0;
    out_ack = 1'b0;
    void'($urandom(32'ha4a751c1));
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_idle();
    test_single_uop();
    test_group_of_eight();
    test_back_to_back();
    test_back_pressure();
    repeat (5) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "micro-ops still expected at the end of the run");
    end
  end

endmodule

//--- tb.f
rvv_pkg.sv
rvv_cmd_queue.sv
rvv_decode_unit.sv
rvv_decode_ctrl.sv
rvv_uop_queue.sv
rvv_decode_top.sv
rvv_decode_tb.sv

//--- Bender.yml
package:
  name: rvv_decode

sources:
  - files:
      - rvv_pkg.sv
      - rvv_cmd_queue.sv
      - rvv_decode_unit.sv
      - rvv_decode_ctrl.sv
      - rvv_uop_queue.sv
      - rvv_decode_top.sv
  - target: test
    files:
      - rvv_decode_tb.sv
